//--- project.f
logic/scrub_pkg.sv
logic/shell_ctl_decode.sv
logic/mem_scrubber.sv
logic/scrub_status_readout.sv
logic/cl_scrub_top.sv
test/scrub_checker.sv
test/tb_cl_scrub.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f project.f --top-module tb_cl_scrub -Mdir obj_dir
	./obj_dir/Vtb_cl_scrub | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_cl_scrub.sv
`timescale 1ns/1ps

module tb_cl_scrub;

   localparam int NUM_SEGMENTS = 40;
   localparam int MAX_SEG_LEN  = 35;
   localparam int CYCLE_LIMIT  = NUM_SEGMENTS * MAX_SEG_LEN + 200;

   logic                   clk;
   logic                   sync_rst_n;
   scrub_pkg::ctl_word_t   sh_cl_ctl0;
   logic                   sh_cl_flr_assert;
   logic                   cl_sh_flr_done;
   scrub_pkg::stat_word_t  cl_sh_id0;
   scrub_pkg::stat_word_t  cl_sh_id1;
   scrub_pkg::stat_word_t  cl_sh_status0;
   int                     error_count;

   logic [31:0]            rng_state;
   logic [31:0]            r;
   scrub_pkg::ctl_word_t   word;
   int                     seg;
   int                     seg_len;
   int                     cyc;
   int                     flr_left;
   int                     cycle_count;

   cl_scrub_top UUT
   (
      .clk              (clk),
      .sync_rst_n       (sync_rst_n),
      .sh_cl_ctl0       (sh_cl_ctl0),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .cl_sh_flr_done   (cl_sh_flr_done),
      .cl_sh_id0        (cl_sh_id0),
      .cl_sh_id1        (cl_sh_id1),
      .cl_sh_status0    (cl_sh_status0)
   );

   scrub_checker CHECKER
   (
      .clk              (clk),
      .sync_rst_n       (sync_rst_n),
      .sh_cl_ctl0       (sh_cl_ctl0),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .cl_sh_flr_done   (cl_sh_flr_done),
      .cl_sh_id0        (cl_sh_id0),
      .cl_sh_id1        (cl_sh_id1),
      .cl_sh_status0    (cl_sh_status0),
      .error_count      (error_count)
   );

   // ----------------------------------------
   // Random source
   // ----------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task next_random(output logic [31:0] value);
      rng_state = xorshift32(rng_state);
      value     = rng_state;
   endtask

   // Enables are cleared only one time in four
   task make_ctl_word(output scrub_pkg::ctl_word_t w);
      logic [31:0] e;
      int          k;
      next_random(w);
      next_random(e);
      for (k = 0; k < scrub_pkg::NUM_MEM; k++)
         w[k] = (e[2*k +: 2] != 2'd0);
   endtask

   // FLR spans of 1 to 8 cycles, high about a quarter of the time
   task drive_flr();
      logic [31:0] f;
      if (flr_left == 0)
      begin
         next_random(f);
         flr_left         = 1 + int'(f[2:0]);
         sh_cl_flr_assert = (f[5:3] < 3'd2);
      end
      flr_left--;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial
   begin
      sync_rst_n       = 1'b0;
      sh_cl_ctl0       = '0;
      sh_cl_flr_assert = 1'b0;
      rng_state        = 32'd40;
      flr_left         = 0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;

      for (seg = 0; seg < NUM_SEGMENTS; seg++)
      begin
         make_ctl_word(word);
         next_random(r);
         seg_len = 4 + int'(r[4:0]);
         for (cyc = 0; cyc < seg_len; cyc++)
         begin
            sh_cl_ctl0 = word;
            drive_flr();
            @(negedge clk);
         end
      end

      // Let the last word drain through decode and readout
      sh_cl_ctl0       = '0;
      sh_cl_flr_assert = 1'b0;
      repeat (4) @(negedge clk);

      $display("Closing report: %0d errors", error_count);
      if (error_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial
   begin
      cycle_count = 0;
      wait (sync_rst_n === 1'b1);
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not end within %0d cycles after reset", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
   end

endmodule

//--- test/scrub_checker.sv
`timescale 1ns/1ps

module scrub_checker
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  scrub_pkg::ctl_word_t   sh_cl_ctl0,
   input  logic                   sh_cl_flr_assert,
   input  logic                   cl_sh_flr_done,
   input  scrub_pkg::stat_word_t  cl_sh_id0,
   input  scrub_pkg::stat_word_t  cl_sh_id1,
   input  scrub_pkg::stat_word_t  cl_sh_status0,
   output int                     error_count
);

   // Model memories indexed like the control bits, 0 A, 1 B, 2 D, 3 C
   scrub_pkg::ctl_word_t    ctl_m;
   scrub_pkg::scrb_state_t  st_m [scrub_pkg::NUM_MEM];
   scrub_pkg::scrb_addr_t   addr_m [scrub_pkg::NUM_MEM];
   scrub_pkg::stat_word_t   id0_m;
   scrub_pkg::stat_word_t   id1_m;
   scrub_pkg::stat_word_t   status_m;
   logic                    flr_q_m;
   logic                    flr_done_m;
   scrub_pkg::scrb_addr_t   view_addr;
   int                      i;

   task compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         error_count++;
         $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   // ----------------------------------------
   // One clock of the reference model
   // ----------------------------------------
   // Readout goes first, it sees the decode and scrubber values of the last cycle
   task step_model();
      // Select values 4 to 7 fall back to A
      view_addr = ctl_m[30] ? addr_m[0] : addr_m[ctl_m[29:28]];
      id0_m     = ctl_m[31] ? view_addr[31:0] : scrub_pkg::CL_ID0;
      id1_m     = ctl_m[31] ? view_addr[63:32] : scrub_pkg::CL_ID1;
      status_m  = '0;
      for (i = 0; i < scrub_pkg::NUM_MEM; i++)
         status_m[i] = (st_m[i] == scrub_pkg::SCRB_DONE);
      for (i = 0; i < scrub_pkg::NUM_MEM; i++)
      begin
         if (!ctl_m[i])
         begin
            st_m[i]   = scrub_pkg::SCRB_IDLE;
            addr_m[i] = '0;
         end
         else if (st_m[i] == scrub_pkg::SCRB_IDLE)
            st_m[i] = scrub_pkg::SCRB_RUN;
         else if (st_m[i] == scrub_pkg::SCRB_RUN && addr_m[i] == scrub_pkg::SCRB_LAST_ADDR)
            st_m[i] = scrub_pkg::SCRB_DONE;
         else if (st_m[i] == scrub_pkg::SCRB_RUN)
            addr_m[i] = addr_m[i] + scrub_pkg::SCRB_STEP;
      end
      flr_done_m = flr_q_m && !flr_done_m;
      flr_q_m    = sh_cl_flr_assert;
      ctl_m      = sh_cl_ctl0;
   endtask

   always @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         error_count = 0;
         ctl_m       = '0;
         flr_q_m     = 1'b0;
         flr_done_m  = 1'b0;
         id0_m       = scrub_pkg::CL_ID0;
         id1_m       = scrub_pkg::CL_ID1;
         status_m    = '0;
         for (i = 0; i < scrub_pkg::NUM_MEM; i++)
         begin
            st_m[i]   = scrub_pkg::SCRB_IDLE;
            addr_m[i] = '0;
         end
      end
      else
      begin
         // Outputs are flops, so these are still the values of the last cycle
         compare_word("cl_sh_id0", id0_m, cl_sh_id0);
         compare_word("cl_sh_id1", id1_m, cl_sh_id1);
         compare_word("cl_sh_status0", status_m, cl_sh_status0);
         compare_word("cl_sh_flr_done", {31'd0, flr_done_m}, {31'd0, cl_sh_flr_done});
         step_model();
      end
   end

endmodule

//--- logic/cl_scrub_top.sv
`timescale 1ns/1ps

module cl_scrub_top
(
   input  logic                   clk,
   input  logic                   sync_rst_n,

   input  scrub_pkg::ctl_word_t   sh_cl_ctl0,
   input  logic                   sh_cl_flr_assert,

   output logic                   cl_sh_flr_done,
   output scrub_pkg::stat_word_t  cl_sh_id0,
   output scrub_pkg::stat_word_t  cl_sh_id1,
   output scrub_pkg::stat_word_t  cl_sh_status0
);

   logic                   scrb_en_a;
   logic                   scrb_en_b;
   logic                   scrb_en_c;
   logic                   scrb_en_d;
   logic                   dbg_en;
   scrub_pkg::mem_sel_t    dbg_mem_sel;

   scrub_pkg::scrb_addr_t  addr_a;
   scrub_pkg::scrb_addr_t  addr_b;
   scrub_pkg::scrb_addr_t  addr_c;
   scrub_pkg::scrb_addr_t  addr_d;
   logic                   done_a;
   logic                   done_b;
   logic                   done_c;
   logic                   done_d;

   // ----------------------------------------
   // Control decode and FLR
   // ----------------------------------------
   shell_ctl_decode SHELL_CTL_DECODE
   (
      .clk              (clk),
      .sync_rst_n       (sync_rst_n),
      .sh_cl_ctl0       (sh_cl_ctl0),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .scrb_en_a        (scrb_en_a),
      .scrb_en_b        (scrb_en_b),
      .scrb_en_c        (scrb_en_c),
      .scrb_en_d        (scrb_en_d),
      .dbg_en           (dbg_en),
      .dbg_mem_sel      (dbg_mem_sel),
      .cl_sh_flr_done   (cl_sh_flr_done)
   );

   // ----------------------------------------
   // One scrubber per memory
   // ----------------------------------------
   mem_scrubber SCRB_A
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en_a),
      .scrb_addr  (addr_a),
      .scrb_done  (done_a)
   );

   mem_scrubber SCRB_B
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en_b),
      .scrb_addr  (addr_b),
      .scrb_done  (done_b)
   );

   mem_scrubber SCRB_C
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en_c),
      .scrb_addr  (addr_c),
      .scrb_done  (done_c)
   );

   mem_scrubber SCRB_D
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en_d),
      .scrb_addr  (addr_d),
      .scrb_done  (done_d)
   );

   // ----------------------------------------
   // ID and status readout
   // ----------------------------------------
   scrub_status_readout SCRUB_STATUS_READOUT
   (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .dbg_en        (dbg_en),
      .dbg_mem_sel   (dbg_mem_sel),
      .addr_a        (addr_a),
      .addr_b        (addr_b),
      .addr_c        (addr_c),
      .addr_d        (addr_d),
      .done_a        (done_a),
      .done_b        (done_b),
      .done_c        (done_c),
      .done_d        (done_d),
      .cl_sh_id0     (cl_sh_id0),
      .cl_sh_id1     (cl_sh_id1),
      .cl_sh_status0 (cl_sh_status0)
   );

endmodule

//--- logic/scrub_status_readout.sv
`timescale 1ns/1ps

module scrub_status_readout
(
   input  logic                   clk,
   input  logic                   sync_rst_n,

   input  logic                   dbg_en,
   input  scrub_pkg::mem_sel_t    dbg_mem_sel,

   input  scrub_pkg::scrb_addr_t  addr_a,
   input  scrub_pkg::scrb_addr_t  addr_b,
   input  scrub_pkg::scrb_addr_t  addr_c,
   input  scrub_pkg::scrb_addr_t  addr_d,
   input  logic                   done_a,
   input  logic                   done_b,
   input  logic                   done_c,
   input  logic                   done_d,

   output scrub_pkg::stat_word_t  cl_sh_id0,
   output scrub_pkg::stat_word_t  cl_sh_id1,
   output scrub_pkg::stat_word_t  cl_sh_status0
);

   scrub_pkg::scrb_addr_t          sel_addr;
   scrub_pkg::stat_word_t          id0_nxt;
   scrub_pkg::stat_word_t          id1_nxt;
   scrub_pkg::stat_word_t          status_nxt;
   logic [scrub_pkg::NUM_MEM-1:0]  done_vec;

   // ----------------------------------------
   // Debug address select
   // ----------------------------------------
   always_comb
   begin
      case (dbg_mem_sel)
         3'd1:    sel_addr = addr_b;
         3'd2:    sel_addr = addr_d;
         3'd3:    sel_addr = addr_c;
         default: sel_addr = addr_a;
      endcase
   end

   // Fixed card IDs unless debug view is on
   assign id0_nxt = dbg_en ? sel_addr[31:0]  : scrub_pkg::CL_ID0;
   assign id1_nxt = dbg_en ? sel_addr[63:32] : scrub_pkg::CL_ID1;

   // Done flags, C in bit 3 down to A in bit 0
   assign done_vec = {done_c, done_d, done_b, done_a};

   always_comb
   begin
      status_nxt = '0;
      status_nxt[scrub_pkg::NUM_MEM-1:0] = done_vec;
   end

   // ----------------------------------------
   // Output registers
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         cl_sh_id0     <= scrub_pkg::CL_ID0;
         cl_sh_id1     <= scrub_pkg::CL_ID1;
         cl_sh_status0 <= '0;
      end
      else
      begin
         cl_sh_id0     <= id0_nxt;
         cl_sh_id1     <= id1_nxt;
         cl_sh_status0 <= status_nxt;
      end
   end

endmodule

//--- logic/mem_scrubber.sv
`timescale 1ns/1ps

module mem_scrubber
(
   input  logic                   clk,
   input  logic                   sync_rst_n,

   input  logic                   scrb_en,

   output scrub_pkg::scrb_addr_t  scrb_addr,
   output logic                   scrb_done
);

   scrub_pkg::scrb_state_t state;
   scrub_pkg::scrb_state_t state_nxt;
   scrub_pkg::scrb_addr_t  addr_nxt;

   // ----------------------------------------
   // Next state and address
   // ----------------------------------------
   always_comb
   begin
      state_nxt = state;
      addr_nxt  = scrb_addr;

      if (!scrb_en)
      begin
         // Dropping the enable restarts the walk from zero
         state_nxt = scrub_pkg::SCRB_IDLE;
         addr_nxt  = '0;
      end
      else
      begin
         case (state)
            scrub_pkg::SCRB_IDLE:
               state_nxt = scrub_pkg::SCRB_RUN;
            scrub_pkg::SCRB_RUN:
               if (scrb_addr == scrub_pkg::SCRB_LAST_ADDR)
                  state_nxt = scrub_pkg::SCRB_DONE;
               else
                  addr_nxt = scrb_addr + scrub_pkg::SCRB_STEP;
            scrub_pkg::SCRB_DONE:
               // Hold last burst address until disabled
               state_nxt = scrub_pkg::SCRB_DONE;
            default:
               state_nxt = scrub_pkg::SCRB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state     <= scrub_pkg::SCRB_IDLE;
         scrb_addr <= '0;
      end
      else
      begin
         state     <= state_nxt;
         scrb_addr <= addr_nxt;
      end
   end

   assign scrb_done = (state == scrub_pkg::SCRB_DONE);

endmodule

//--- logic/shell_ctl_decode.sv
`timescale 1ns/1ps

module shell_ctl_decode
(
   input  logic                  clk,
   input  logic                  sync_rst_n,

   input  scrub_pkg::ctl_word_t  sh_cl_ctl0,
   input  logic                  sh_cl_flr_assert,

   output logic                  scrb_en_a,
   output logic                  scrb_en_b,
   output logic                  scrb_en_c,
   output logic                  scrb_en_d,
   output logic                  dbg_en,
   output scrub_pkg::mem_sel_t   dbg_mem_sel,
   output logic                  cl_sh_flr_done
);

   scrub_pkg::ctl_word_t ctl_q;
   logic                 flr_assert_q;

   // ----------------------------------------
   // Control word register
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         ctl_q <= '0;
      else
         ctl_q <= sh_cl_ctl0;
   end

   // Low nibble enables memories A, B, D, C from bit 0 up
   assign scrb_en_a = ctl_q[0];
   assign scrb_en_b = ctl_q[1];
   assign scrb_en_d = ctl_q[2];
   assign scrb_en_c = ctl_q[3];

   // Debug view of one scrubber address on the ID outputs
   assign dbg_en      = ctl_q[scrub_pkg::CTL_DBG_EN_BIT];
   assign dbg_mem_sel = ctl_q[scrub_pkg::CTL_MEM_SEL_LSB +: $bits(scrub_pkg::mem_sel_t)];

   // ----------------------------------------
   // FLR acknowledge
   // ----------------------------------------
   // Done pulses one cycle and then drops, so a held assert toggles it
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

endmodule

//--- logic/scrub_pkg.sv
package scrub_pkg;

   // Shell facing words
   typedef logic [31:0] ctl_word_t;
   typedef logic [31:0] stat_word_t;

   // Scrubber byte address
   typedef logic [63:0] scrb_addr_t;

   // Debug memory select, 0 A, 1 B, 2 D, 3 C, others fall back to A
   typedef logic [2:0] mem_sel_t;

   typedef enum logic [1:0]
   {
      SCRB_IDLE = 2'd0,
      SCRB_RUN  = 2'd1,
      SCRB_DONE = 2'd2
   } scrb_state_t;

   localparam int NUM_MEM = 4;

   // Control word fields
   localparam int CTL_DBG_EN_BIT  = 31;
   localparam int CTL_MEM_SEL_LSB = 28;

   // Simulation scrub range, 8 KiB walked in bursts of 16 x 64 bytes
   localparam scrb_addr_t SCRB_STEP      = scrb_addr_t'(16 * 64);
   localparam scrb_addr_t SCRB_MAX_ADDR  = 64'h1FFF;
   localparam scrb_addr_t SCRB_LAST_ADDR = SCRB_MAX_ADDR + 64'd1 - SCRB_STEP;

   // Card identification words
   localparam stat_word_t CL_ID0 = 32'hF000_1D0F;
   localparam stat_word_t CL_ID1 = 32'h1D51_FEDC;

endpackage
